// File: rtl/isaPkg.sv
// Instruction set of the 16-bit core. Opcode values follow the five-bit
// field in bits 15..11; any code not listed here is illegal
package isaPkg;

    // Data and instruction word
    localparam int WordW = 16;
    localparam int RegIdxW = 3;

    // Instruction fields
    localparam int OpcodeW = 5;
    localparam int FunctW = 2;
    localparam int Imm5W = 5;
    localparam int Imm8W = 8;
    localparam int Disp11W = 11;

    // Low bit of each register field
    localparam int RsLsb = 8;
    localparam int RtLsb = 5;
    localparam int RdLsb = 2;

    // jal writes its return address here
    localparam logic [RegIdxW-1:0] LinkReg = '1;

    typedef enum logic [OpcodeW-1:0] {
        halt  = 5'b00000,
        nop   = 5'b00001,
        j     = 5'b00100,
        jal   = 5'b00110,
        addi  = 5'b01000,
        subi  = 5'b01001,
        xori  = 5'b01010,
        andni = 5'b01011,
        beqz  = 5'b01100,
        bnez  = 5'b01101,
        st    = 5'b10000,
        ld    = 5'b10001,
        slbi  = 5'b10010,
        lbi   = 5'b11000,
        rType = 5'b11011
    } opcodeT;

    // Class of ALU work; rType defers to the function bits
    typedef enum logic [2:0] {
        aluAdd, aluSub, aluXor, aluAndn, aluPass, aluShift, aluRType
    } aluOpT;

endpackage

// File: rtl/pipePkg.sv
// Bundles that cross the decode stage and the decode/execute boundary.
// Field encodings below are shared by the decoder and the stage top
package pipePkg;
    import isaPkg::*;

    // regDst choices
    localparam logic [1:0] RegDstRt = 2'd0;
    localparam logic [1:0] RegDstRs = 2'd1;
    localparam logic [1:0] RegDstRd = 2'd2;
    localparam logic [1:0] RegDstLink = 2'd3;

    // regSrc choices for the write-back value
    localparam logic [1:0] RegSrcAlu = 2'd0;
    localparam logic [1:0] RegSrcMem = 2'd1;
    localparam logic [1:0] RegSrcPc = 2'd2;

    // Second ALU operand
    localparam logic [1:0] BSrcReg = 2'd0;
    localparam logic [1:0] BSrcImm = 2'd1;
    localparam logic [1:0] BSrcZero = 2'd2;

    // One-hot branch conditions
    localparam logic [3:0] BrNone = 4'b0000;
    localparam logic [3:0] BrEqz = 4'b0001;
    localparam logic [3:0] BrNez = 4'b0010;

    typedef struct packed {
        logic memRead;
        logic memWrite;
        logic immSrc;
        logic aluSign;
        logic aluJump;
        logic regWrite;
        logic [1:0] regSrc;
        logic [1:0] bSrc;
        logic [3:0] branchCond;
        logic zeroExt;
        logic [1:0] regDst;
        aluOpT aluOp;
        logic halt;
        logic err;
    } ctrlT;

    // Control levels that move on to execute
    typedef struct packed {
        logic memRead;
        logic memWrite;
        logic immSrc;
        logic aluSign;
        logic aluJump;
        logic regWrite;
        logic [1:0] regSrc;
        logic [1:0] bSrc;
        logic [3:0] branchCond;
        aluOpT aluOp;
        logic halt;
        logic err;
    } exCtrlT;

    typedef struct packed {
        logic [3:0] aluOper;
        logic invA;
        logic invB;
        logic cin;
    } aluCtrlT;

    typedef struct packed {
        exCtrlT ctrl;
        aluCtrlT alu;
        logic [WordW-1:0] rsData;
        logic [WordW-1:0] rtData;
        logic [WordW-1:0] imm5;
        logic [WordW-1:0] imm8;
        logic [WordW-1:0] sImm8;
        logic [WordW-1:0] sImm11;
        logic [WordW-1:0] pcNext;
        logic [RegIdxW-1:0] rd;
    } decExT;

    // One entry of the write-back delay line
    typedef struct packed {
        logic regWrite;
        logic [RegIdxW-1:0] rd;
    } wbTagT;

endpackage

// File: rtl/instrControl.sv
// Purely combinational opcode decode. Illegal opcodes raise err and
// never write a register or memory
module instrControl import isaPkg::*; import pipePkg::*; (
    input  logic [WordW-1:0] instr,
    output ctrlT             ctrl
);

    opcodeT op;

    assign op = opcodeT'(instr[WordW-1 -: OpcodeW]);

    always_comb begin
        // Quiet defaults match nop
        ctrl.memRead = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.immSrc = 1'b0;
        ctrl.aluSign = 1'b0;
        ctrl.aluJump = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.regSrc = RegSrcAlu;
        ctrl.bSrc = BSrcReg;
        ctrl.branchCond = BrNone;
        ctrl.zeroExt = 1'b0;
        ctrl.regDst = RegDstRt;
        ctrl.aluOp = aluAdd;
        ctrl.halt = 1'b0;
        ctrl.err = 1'b0;

        case (op)
            halt: ctrl.halt = 1'b1;
            nop: ctrl.err = 1'b0;
            addi, subi: begin
                ctrl.regWrite = 1'b1;
                ctrl.bSrc = BSrcImm;
                ctrl.aluSign = 1'b1;
                ctrl.aluOp = (op == subi) ? aluSub : aluAdd;
            end
            xori, andni: begin
                ctrl.regWrite = 1'b1;
                ctrl.bSrc = BSrcImm;
                ctrl.zeroExt = 1'b1;
                ctrl.aluOp = (op == xori) ? aluXor : aluAndn;
            end
            slbi: begin
                ctrl.regWrite = 1'b1;
                ctrl.bSrc = BSrcImm;
                ctrl.immSrc = 1'b1;
                ctrl.zeroExt = 1'b1;
                ctrl.regDst = RegDstRs;
                ctrl.aluOp = aluShift;
            end
            lbi: begin
                ctrl.regWrite = 1'b1;
                ctrl.bSrc = BSrcImm;
                ctrl.immSrc = 1'b1;
                ctrl.regDst = RegDstRs;
                ctrl.aluOp = aluPass;
            end
            ld: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.bSrc = BSrcImm;
                ctrl.aluSign = 1'b1;
                ctrl.regSrc = RegSrcMem;
            end
            st: begin
                ctrl.memWrite = 1'b1;
                ctrl.bSrc = BSrcImm;
                ctrl.aluSign = 1'b1;
            end
            beqz, bnez: begin
                // Rs is compared against zero in execute
                ctrl.bSrc = BSrcZero;
                ctrl.immSrc = 1'b1;
                ctrl.aluSign = 1'b1;
                ctrl.aluOp = aluPass;
                ctrl.branchCond = (op == beqz) ? BrEqz : BrNez;
            end
            j: ctrl.aluJump = 1'b1;
            jal: begin
                ctrl.aluJump = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regSrc = RegSrcPc;
                ctrl.regDst = RegDstLink;
            end
            rType: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst = RegDstRd;
                ctrl.aluSign = 1'b1;
                ctrl.aluOp = aluRType;
            end
            default: begin
                ctrl.err = 1'b1;
                ctrl.regWrite = 1'b0;
                ctrl.memWrite = 1'b0;
            end
        endcase
    end

endmodule

// File: rtl/aluControl.sv
// Turns the ALU class into the operation code seen by execute.
// Subtraction is B + ~A + 1, so it computes B minus A
module aluControl import isaPkg::*; import pipePkg::*; (
    input  aluOpT             aluOp,
    input  logic [FunctW-1:0] funct,
    output aluCtrlT           aluCtrl
);

    localparam logic [3:0] OperAdd = 4'd0;
    localparam logic [3:0] OperXor = 4'd1;
    localparam logic [3:0] OperAnd = 4'd2;
    localparam logic [3:0] OperPass = 4'd3;
    localparam logic [3:0] OperShift = 4'd4;

    always_comb begin
        aluCtrl = '{aluOper: OperAdd, invA: 1'b0, invB: 1'b0, cin: 1'b0};
        case (aluOp)
            aluSub: begin
                aluCtrl.invA = 1'b1;
                aluCtrl.cin = 1'b1;
            end
            aluXor: aluCtrl.aluOper = OperXor;
            aluAndn: begin
                aluCtrl.aluOper = OperAnd;
                aluCtrl.invB = 1'b1;
            end
            aluPass: aluCtrl.aluOper = OperPass;
            // Shift left by eight, then or in the immediate
            aluShift: aluCtrl.aluOper = OperShift;
            aluRType: begin
                case (funct)
                    2'b00: aluCtrl.aluOper = OperAdd;
                    2'b01: begin
                        aluCtrl.invA = 1'b1;
                        aluCtrl.cin = 1'b1;
                    end
                    2'b10: aluCtrl.aluOper = OperXor;
                    default: begin
                        aluCtrl.aluOper = OperAnd;
                        aluCtrl.invB = 1'b1;
                    end
                endcase
            end
            // aluAdd and the unused class code
            default: aluCtrl.aluOper = OperAdd;
        endcase
    end

endmodule

// File: rtl/regFile.sv
// Eight registers, two combinational reads, one write per clock.
// There is no bypass, so a read during a write sees the old contents
module regFile import isaPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [RegIdxW-1:0] rsSel,
    input  logic [RegIdxW-1:0] rtSel,
    input  logic [RegIdxW-1:0] wrSel,
    input  logic [WordW-1:0]   wrData,
    input  logic               wrEn,
    output logic [WordW-1:0]   rsData,
    output logic [WordW-1:0]   rtData
);

    localparam int NumRegs = 1 << RegIdxW;

    logic [WordW-1:0] regs [NumRegs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrSel] <= wrData;
        end
    end

    assign rsData = regs[rsSel];
    assign rtData = regs[rtSel];

endmodule

// File: rtl/decodeStage.sv
// Decode stage top. No enable or stall: one instruction enters per clock.
// WbDelay must be at least 1; wbData must line up with regWriteWb
module decodeStage import isaPkg::*; import pipePkg::*; #(
    parameter int WbDelay = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [WordW-1:0]   instr,
    input  logic [WordW-1:0]   pc,
    input  logic [WordW-1:0]   wbData,
    output decExT              decEx,
    output logic [RegIdxW-1:0] rdWb,
    output logic               regWriteWb,
    output logic               haltComb
);

    ctrlT ctrl;
    aluCtrlT aluCtrl;
    logic [WordW-1:0] rsData;
    logic [WordW-1:0] rtData;
    logic [RegIdxW-1:0] rdSel;
    logic [WordW-1:0] imm5;
    logic [WordW-1:0] imm8;
    logic [WordW-1:0] sImm8;
    logic [WordW-1:0] sImm11;
    decExT decNext;
    wbTagT wbLine [WbDelay];

    instrControl uInstrControl (
        .instr (instr),
        .ctrl  (ctrl)
    );

    aluControl uAluControl (
        .aluOp   (ctrl.aluOp),
        .funct   (instr[FunctW-1:0]),
        .aluCtrl (aluCtrl)
    );

    regFile uRegFile (
        .clk    (clk),
        .rst    (rst),
        .rsSel  (instr[RsLsb +: RegIdxW]),
        .rtSel  (instr[RtLsb +: RegIdxW]),
        .wrSel  (rdWb),
        .wrData (wbData),
        .wrEn   (regWriteWb),
        .rsData (rsData),
        .rtData (rtData)
    );

    // Destination register
    always_comb begin
        case (ctrl.regDst)
            RegDstRt: rdSel = instr[RtLsb +: RegIdxW];
            RegDstRs: rdSel = instr[RsLsb +: RegIdxW];
            RegDstRd: rdSel = instr[RdLsb +: RegIdxW];
            RegDstLink: rdSel = LinkReg;
        endcase
    end

    // Immediate views
    assign imm5 = ctrl.zeroExt ? {{(WordW - Imm5W){1'b0}}, instr[Imm5W-1:0]}
                               : {{(WordW - Imm5W){instr[Imm5W-1]}}, instr[Imm5W-1:0]};
    assign sImm8 = {{(WordW - Imm8W){instr[Imm8W-1]}}, instr[Imm8W-1:0]};
    assign imm8 = ctrl.zeroExt ? {{(WordW - Imm8W){1'b0}}, instr[Imm8W-1:0]} : sImm8;
    assign sImm11 = {{(WordW - Disp11W){instr[Disp11W-1]}}, instr[Disp11W-1:0]};

    assign haltComb = ctrl.halt;

    always_comb begin
        decNext.ctrl = '{
            memRead: ctrl.memRead,
            memWrite: ctrl.memWrite,
            immSrc: ctrl.immSrc,
            aluSign: ctrl.aluSign,
            aluJump: ctrl.aluJump,
            regWrite: ctrl.regWrite,
            regSrc: ctrl.regSrc,
            bSrc: ctrl.bSrc,
            branchCond: ctrl.branchCond,
            aluOp: ctrl.aluOp,
            halt: ctrl.halt,
            err: ctrl.err
        };
        decNext.alu = aluCtrl;
        decNext.rsData = rsData;
        decNext.rtData = rtData;
        decNext.imm5 = imm5;
        decNext.imm8 = imm8;
        decNext.sImm8 = sImm8;
        decNext.sImm11 = sImm11;
        decNext.pcNext = pc;
        decNext.rd = rdSel;
    end

    // Decode/execute boundary register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decEx <= '0;
        end else begin
            decEx <= decNext;
        end
    end

    // Write-back tag travels alongside the rest of the pipe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < WbDelay; i++) begin
                wbLine[i] <= '0;
            end
        end else begin
            wbLine[0] <= '{regWrite: ctrl.regWrite, rd: rdSel};
            for (int i = 1; i < WbDelay; i++) begin
                wbLine[i] <= wbLine[i-1];
            end
        end
    end

    assign rdWb = wbLine[WbDelay-1].rd;
    assign regWriteWb = wbLine[WbDelay-1].regWrite;

endmodule

// File: tests/decodeModel.svh
// Reference model of the decode stage for the testbench. Needs WbDepth
// and the package types to be visible where it is included
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

opcodeT legalOps [15] = '{halt, nop, addi, subi, xori, andni, slbi, lbi,
                         ld, st, beqz, bnez, j, jal, rType};

logic [WordW-1:0] shadowRegs [8];
// Oldest entry is the write-back due in the current cycle
wbTagT pendingWb [$];
decExT expDecEx;

// Sub is an add with A inverted and a carry in
function automatic aluCtrlT expectAlu(aluOpT cls, logic [1:0] funct);
    aluCtrlT a;
    aluOpT eff;
    a = '0;
    eff = cls;
    if (cls == aluRType) begin
        eff = (funct == 2'd0) ? aluAdd : (funct == 2'd1) ? aluSub :
              (funct == 2'd2) ? aluXor : aluAndn;
    end
    case (eff)
        aluSub: begin
            a.invA = 1'b1;
            a.cin = 1'b1;
        end
        aluXor: a.aluOper = 4'd1;
        aluAndn: begin
            a.aluOper = 4'd2;
            a.invB = 1'b1;
        end
        aluPass: a.aluOper = 4'd3;
        aluShift: a.aluOper = 4'd4;
        default: a.aluOper = 4'd0;
    endcase
    return a;
endfunction

function automatic decExT expectDecode(logic [WordW-1:0] ins, logic [WordW-1:0] pcIn);
    decExT e;
    logic zext;
    logic [1:0] dst;
    e = '0;
    zext = 1'b0;
    dst = RegDstRt;
    case (ins[15:11])
        halt: e.ctrl.halt = 1'b1;
        nop: e.ctrl.halt = 1'b0;
        addi, subi: begin
            e.ctrl.regWrite = 1'b1;
            e.ctrl.bSrc = BSrcImm;
            e.ctrl.aluSign = 1'b1;
            e.ctrl.aluOp = (ins[15:11] == subi) ? aluSub : aluAdd;
        end
        xori, andni: begin
            e.ctrl.regWrite = 1'b1;
            e.ctrl.bSrc = BSrcImm;
            zext = 1'b1;
            e.ctrl.aluOp = (ins[15:11] == xori) ? aluXor : aluAndn;
        end
        slbi, lbi: begin
            // Both write Rs and slbi keeps the old value shifted up
            e.ctrl.regWrite = 1'b1;
            e.ctrl.bSrc = BSrcImm;
            e.ctrl.immSrc = 1'b1;
            dst = RegDstRs;
            zext = (ins[15:11] == slbi);
            e.ctrl.aluOp = (ins[15:11] == slbi) ? aluShift : aluPass;
        end
        ld, st: begin
            e.ctrl.regWrite = (ins[15:11] == ld);
            e.ctrl.memRead = (ins[15:11] == ld);
            e.ctrl.memWrite = (ins[15:11] == st);
            e.ctrl.bSrc = BSrcImm;
            e.ctrl.aluSign = 1'b1;
            e.ctrl.regSrc = (ins[15:11] == ld) ? RegSrcMem : RegSrcAlu;
        end
        beqz, bnez: begin
            e.ctrl.bSrc = BSrcZero;
            e.ctrl.immSrc = 1'b1;
            e.ctrl.aluSign = 1'b1;
            e.ctrl.aluOp = aluPass;
            e.ctrl.branchCond = (ins[15:11] == beqz) ? BrEqz : BrNez;
        end
        j: e.ctrl.aluJump = 1'b1;
        jal: begin
            e.ctrl.aluJump = 1'b1;
            e.ctrl.regWrite = 1'b1;
            e.ctrl.regSrc = RegSrcPc;
            dst = RegDstLink;
        end
        rType: begin
            e.ctrl.regWrite = 1'b1;
            e.ctrl.aluSign = 1'b1;
            e.ctrl.aluOp = aluRType;
            dst = RegDstRd;
        end
        default: e.ctrl.err = 1'b1;
    endcase
    e.alu = expectAlu(e.ctrl.aluOp, ins[1:0]);
    e.rsData = shadowRegs[ins[10:8]];
    e.rtData = shadowRegs[ins[7:5]];
    e.imm5 = zext ? {11'b0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
    e.sImm8 = {{8{ins[7]}}, ins[7:0]};
    e.imm8 = zext ? {8'b0, ins[7:0]} : e.sImm8;
    e.sImm11 = {{5{ins[10]}}, ins[10:0]};
    e.pcNext = pcIn;
    case (dst)
        RegDstRt: e.rd = ins[7:5];
        RegDstRs: e.rd = ins[10:8];
        RegDstRd: e.rd = ins[4:2];
        default: e.rd = 3'd7;
    endcase
    return e;
endfunction

task automatic resetModel();
    foreach (shadowRegs[i]) begin
        shadowRegs[i] = '0;
    end
    pendingWb.delete();
    for (int i = 0; i < WbDepth; i++) begin
        pendingWb.push_back('0);
    end
    expDecEx = '0;
endtask

// Reads happen before the write of the same cycle lands
task automatic advanceModel(logic [WordW-1:0] ins, logic [WordW-1:0] pcIn,
                            logic [WordW-1:0] wbIn);
    wbTagT done;
    wbTagT tag;
    expDecEx = expectDecode(ins, pcIn);
    done = pendingWb.pop_front();
    if (done.regWrite) begin
        shadowRegs[done.rd] = wbIn;
    end
    tag.regWrite = expDecEx.ctrl.regWrite;
    tag.rd = expDecEx.rd;
    pendingWb.push_back(tag);
endtask

`endif

// File: tests/decodeTb.sv
// Random instruction stream through the decode stage, checked against
// the model every cycle. Stops at the first mismatch
module decodeTb import isaPkg::*; import pipePkg::*; ();

    localparam int WbDepth = 3;
    localparam int NumCycles = 2000;
    localparam int ResetTimeout = 40;

    logic clk;
    logic rst;
    logic [WordW-1:0] instr;
    logic [WordW-1:0] pc;
    logic [WordW-1:0] wbData;
    decExT decEx;
    logic [RegIdxW-1:0] rdWb;
    logic regWriteWb;
    logic haltComb;
    integer seed = 11700;

    `include "decodeModel.svh"

    decodeStage #(.WbDelay(WbDepth)) DUT (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .pc         (pc),
        .wbData     (wbData),
        .decEx      (decEx),
        .rdWb       (rdWb),
        .regWriteWb (regWriteWb),
        .haltComb   (haltComb)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
    end

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // Returns on a falling edge once rst is low
    task automatic waitForReset();
        int waited;
        waited = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > ResetTimeout) begin
                $display("reset was not released within %0d cycles", ResetTimeout);
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end
    endtask

    // Half of the opcodes come from the legal list, the rest from all 32 codes
    task automatic driveRandom();
        logic [31:0] rnd;
        logic [31:0] opRnd;
        logic [31:0] dataRnd;
        logic [3:0] pick;
        logic [4:0] code;
        rnd = $random(seed);
        opRnd = $random(seed);
        dataRnd = $random(seed);
        if (opRnd[31]) begin
            pick = 4'(opRnd[7:0] % 8'd15);
            code = legalOps[pick];
        end else begin
            code = opRnd[4:0];
        end
        instr = {code, rnd[10:0]};
        pc = rnd[31:16];
        wbData = dataRnd[15:0];
    endtask

    task automatic checkOutputs();
        wbTagT due;
        decExT now;
        due = pendingWb[0];
        now = expectDecode(instr, pc);
        check("decEx.ctrl.err", 32'(expDecEx.ctrl.err), 32'(decEx.ctrl.err));
        check("decEx.ctrl.regWrite", 32'(expDecEx.ctrl.regWrite), 32'(decEx.ctrl.regWrite));
        check("decEx.ctrl.memWrite", 32'(expDecEx.ctrl.memWrite), 32'(decEx.ctrl.memWrite));
        check("decEx.ctrl.halt", 32'(expDecEx.ctrl.halt), 32'(decEx.ctrl.halt));
        check("decEx.ctrl", 32'(expDecEx.ctrl), 32'(decEx.ctrl));
        check("decEx.alu", 32'(expDecEx.alu), 32'(decEx.alu));
        check("decEx.rsData", 32'(expDecEx.rsData), 32'(decEx.rsData));
        check("decEx.rtData", 32'(expDecEx.rtData), 32'(decEx.rtData));
        check("decEx.imm5", 32'(expDecEx.imm5), 32'(decEx.imm5));
        check("decEx.imm8", 32'(expDecEx.imm8), 32'(decEx.imm8));
        check("decEx.sImm8", 32'(expDecEx.sImm8), 32'(decEx.sImm8));
        check("decEx.sImm11", 32'(expDecEx.sImm11), 32'(decEx.sImm11));
        check("decEx.pcNext", 32'(expDecEx.pcNext), 32'(decEx.pcNext));
        check("decEx.rd", 32'(expDecEx.rd), 32'(decEx.rd));
        check("rdWb", 32'(due.rd), 32'(rdWb));
        check("regWriteWb", 32'(due.regWrite), 32'(regWriteWb));
        check("haltComb", 32'(now.ctrl.halt), 32'(haltComb));
    endtask

    initial begin
        instr = '0;
        pc = '0;
        wbData = '0;
        resetModel();
        waitForReset();
        // First check sees the cleared pipe; held inputs are the first instruction
        checkOutputs();
        advanceModel(instr, pc, wbData);
        for (int cyc = 0; cyc < NumCycles; cyc++) begin
            @(posedge clk);
            #1;
            driveRandom();
            @(negedge clk);
            checkOutputs();
            advanceModel(instr, pc, wbData);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: sources.f
+incdir+tests
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/instrControl.sv
rtl/aluControl.sv
rtl/regFile.sv
rtl/decodeStage.sv
tests/decodeTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= decodeTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
